/* tb.f */
decodePkg.sv
instrController.sv
registerFile.sv
branchResolve.sv
idExPipeReg.sv
decodeStage.sv
tb_decodeStage.sv

/* Bender.yml */
package:
  name: decode_stage

sources:
  - decodePkg.sv
  - instrController.sv
  - registerFile.sv
  - branchResolve.sv
  - idExPipeReg.sv
  - decodeStage.sv
  - target: test
    files:
      - tb_decodeStage.sv

/* tb_decodeStage.sv */
module tb_decodeStage import decodePkg::*; ();

  timeunit 1ns;
  timeprecision 1ps;

  // Cycle budget of each test
  // Run stops at twice the sum
  localparam int ResetCycles   = 6;
  localparam int RegFileCycles = 74;
  localparam int ImmCycles     = 24;
  localparam int BranchCycles  = 16;
  localparam int LoadUseCycles = 12;
  localparam int TimeoutLimit  = 2 * (ResetCycles + RegFileCycles + ImmCycles +
                                      BranchCycles + LoadUseCycles);

  // All-zero word decodes as a bubble
  localparam logic [31:0] Nop = 32'd0;

  logic        Clock = 1'b0;
  logic        arstN;
  logic [31:0] instr;
  logic [31:0] pcPlusFour;
  logic        wbEn;
  logic [4:0]  wbAddr;
  logic [31:0] wbData;
  logic        pcSel;
  logic [31:0] branchPc;
  logic        stall;
  logic        exRegWrite;
  logic        exMemRead;
  logic        exMemWrite;
  logic        exMemToReg;
  logic        exAluSrcImm;
  aluOpT       exAluOp;
  memWidthT    exMemWidth;
  logic [4:0]  exDestAddr;
  logic [31:0] exRsData;
  logic [31:0] exRtData;
  logic [31:0] exImm32;
  logic [31:0] exLinkPc;

  // Mirror of every register write
  logic [31:0] regMirror [32];
  logic [31:0] lcgState;
  int          cycleCount;
  int          checkCount;
  int          errorCount;
  int          testErrorBase;

  decodeStage decodeStage_inst (.*);

  always #10 Clock = ~Clock;

  // Watchdog
  always @(posedge Clock) begin
    cycleCount++;
    if (cycleCount >= TimeoutLimit) begin
      $display("Run timed out after %0d cycles", cycleCount);
      $display("Something failed");
      $finish;
    end
  end

  //////////////////////////////////////////////////
  // Reference helpers
  //////////////////////////////////////////////////

  function automatic logic [31:0] nextRand();
    lcgState = lcgState * 32'd1664525 + 32'd1013904223;
    return lcgState;
  endfunction

  // Nonzero register number from the upper LCG bits
  function automatic logic [4:0] randReg();
    return 5'((nextRand() >> 16) % 31) + 5'd1;
  endfunction

  function automatic logic [31:0] encodeR(input logic [4:0] rs, input logic [4:0] rt,
                                          input logic [4:0] rd, input logic [5:0] fn);
    return {OpRType, rs, rt, rd, 5'd0, fn};
  endfunction

  function automatic logic [31:0] encodeI(input logic [5:0] op, input logic [4:0] rs,
                                          input logic [4:0] rt, input logic [15:0] imm);
    return {op, rs, rt, imm};
  endfunction

  function automatic logic [31:0] encodeJ(input logic [5:0] op, input logic [25:0] index);
    return {op, index};
  endfunction

  function automatic logic [31:0] signExt(input logic [15:0] imm);
    return {{16{imm[15]}}, imm};
  endfunction

  // Word offset added to the next pc
  function automatic logic [31:0] branchTargetOf(input logic [31:0] pc,
                                                 input logic [15:0] imm);
    return pc + (signExt(imm) << 2);
  endfunction

  // Region bits of pc with the shifted index
  function automatic logic [31:0] jumpTargetOf(input logic [31:0] pc,
                                               input logic [25:0] index);
    return {pc[31:28], index, 2'b00};
  endfunction

  //////////////////////////////////////////////////
  // Checking and driving
  //////////////////////////////////////////////////

  task automatic checkValue(input string name, input logic [31:0] got,
                            input logic [31:0] expected);
    checkCount++;
    if (got !== expected) begin
      errorCount++;
      $display("[FAIL] %s: got 0x%08h, expected 0x%08h", name, got, expected);
    end
  endtask

  task automatic finishTest(input string name);
    $display("Test %-14s finished with %0d mismatches", name, errorCount - testErrorBase);
    testErrorBase = errorCount;
  endtask

  // Drive at the rising edge, sample at the falling edge
  task automatic presentInstr(input logic [31:0] word, input logic [31:0] pc);
    @(posedge Clock);
    instr      <= word;
    pcPlusFour <= pc;
    wbEn       <= 1'b0;
    @(negedge Clock);
  endtask

  // Instruction and writeback in the same cycle
  task automatic presentWithWrite(input logic [31:0] word, input logic [31:0] pc,
                                  input logic [4:0] addr, input logic [31:0] data);
    @(posedge Clock);
    instr      <= word;
    pcPlusFour <= pc;
    wbEn       <= 1'b1;
    wbAddr     <= addr;
    wbData     <= data;
    if (addr != 5'd0) begin
      regMirror[addr] = data;
    end
    @(negedge Clock);
  endtask

  task automatic writeReg(input logic [4:0] addr, input logic [31:0] data);
    presentWithWrite(Nop, 32'd0, addr, data);
  endtask

  // Word then a nop so its ex fields are visible
  task automatic decodeThrough(input logic [31:0] word, input logic [31:0] pc);
    presentInstr(word, pc);
    presentInstr(Nop, pc + 32'd4);
  endtask

  //////////////////////////////////////////////////
  // Directed tests
  //////////////////////////////////////////////////

  task automatic testReset();
    checkValue("exRegWrite", exRegWrite, 1'b0);
    checkValue("exMemRead", exMemRead, 1'b0);
    checkValue("exMemWrite", exMemWrite, 1'b0);
    checkValue("exMemToReg", exMemToReg, 1'b0);
    checkValue("stall", stall, 1'b0);
    finishTest("reset");
  endtask

  task automatic testRegisterFile();
    logic [5:0]  fns [5] = '{FnAdd, FnSub, FnAnd, FnOr, FnSlt};
    aluOpT       ops [5] = '{AluAdd, AluSub, AluAnd, AluOr, AluSlt};
    logic [4:0]  rs;
    logic [4:0]  rt;
    logic [4:0]  rd;
    logic [31:0] value;
    for (int r = 1; r < 32; r++) begin
      writeReg(5'(r), nextRand());
    end
    // Read every register back in rs and rt pairs
    for (int i = 0; i < 16; i++) begin
      rs = 5'(2 * i + 1);
      rt = 5'(2 * i + 2);
      rd = randReg();
      decodeThrough(encodeR(rs, rt, rd, fns[i % 5]), 32'h0000_1000);
      checkValue("exAluOp", exAluOp, ops[i % 5]);
      checkValue("exDestAddr", exDestAddr, rd);
      checkValue("exRegWrite", exRegWrite, 1'b1);
      checkValue("exRsData", exRsData, regMirror[rs]);
      checkValue("exRtData", exRtData, regMirror[rt]);
    end
    // r0 written and read in one cycle
    presentWithWrite(encodeR(5'd0, 5'd0, 5'd3, FnAdd), 32'h0000_2000, 5'd0, nextRand());
    presentInstr(Nop, 32'h0000_2004);
    checkValue("exRsData", exRsData, 32'd0);
    checkValue("exRtData", exRtData, 32'd0);
    // r0 read after the write
    decodeThrough(encodeR(5'd0, 5'd0, 5'd3, FnOr), 32'h0000_2008);
    checkValue("exRsData", exRsData, 32'd0);
    // Same-cycle write to rs
    value = nextRand();
    presentWithWrite(encodeR(5'd7, 5'd8, 5'd9, FnSub), 32'h0000_3000, 5'd7, value);
    presentInstr(Nop, 32'h0000_3004);
    checkValue("exRsData", exRsData, value);
    checkValue("exRtData", exRtData, regMirror[8]);
    finishTest("registerFile");
  endtask

  task automatic testImmediates();
    logic [5:0] memOps [6] = '{OpLw, OpLh, OpLb, OpSw, OpSh, OpSb};
    memWidthT   widths [6] = '{WidthWord, WidthHalf, WidthByte,
                               WidthWord, WidthHalf, WidthByte};
    logic       isLoad;
    decodeThrough(encodeI(OpAddi, 5'd1, 5'd4, 16'h8123), 32'h0000_4000);
    checkValue("exImm32", exImm32, signExt(16'h8123));
    checkValue("exAluSrcImm", exAluSrcImm, 1'b1);
    checkValue("exAluOp", exAluOp, AluAdd);
    checkValue("exDestAddr", exDestAddr, 5'd4);
    checkValue("exRegWrite", exRegWrite, 1'b1);
    // Logic immediates fill with zeros
    decodeThrough(encodeI(OpAndi, 5'd1, 5'd4, 16'h9abc), 32'h0000_4010);
    checkValue("exImm32", exImm32, 32'h0000_9abc);
    checkValue("exAluOp", exAluOp, AluAnd);
    decodeThrough(encodeI(OpOri, 5'd1, 5'd4, 16'hf00f), 32'h0000_4020);
    checkValue("exImm32", exImm32, 32'h0000_f00f);
    checkValue("exAluOp", exAluOp, AluOr);
    decodeThrough(encodeI(OpLui, 5'd0, 5'd7, 16'h1234), 32'h0000_4030);
    checkValue("exAluOp", exAluOp, AluLui);
    checkValue("exRegWrite", exRegWrite, 1'b1);
    checkValue("exDestAddr", exDestAddr, 5'd7);
    // Loads then stores with a negative offset
    for (int i = 0; i < 6; i++) begin
      isLoad = (i < 3);
      decodeThrough(encodeI(memOps[i], 5'd3, 5'd6, 16'hfff0), 32'h0000_4100);
      checkValue("exImm32", exImm32, signExt(16'hfff0));
      checkValue("exMemRead", exMemRead, isLoad);
      checkValue("exMemWrite", exMemWrite, !isLoad);
      checkValue("exRegWrite", exRegWrite, isLoad);
      checkValue("exMemToReg", exMemToReg, isLoad);
      checkValue("exMemWidth", exMemWidth, widths[i]);
    end
    finishTest("immediates");
  endtask

  task automatic testBranches();
    logic [31:0] value;
    logic [31:0] pc;
    logic [15:0] offset;
    logic [25:0] index;
    value  = nextRand();
    pc     = nextRand() & 32'hffff_fffc;
    offset = 16'(nextRand());
    index  = 26'(nextRand());
    writeReg(5'd10, value);
    writeReg(5'd11, value);
    // Equal operands
    presentInstr(encodeI(OpBeq, 5'd10, 5'd11, offset), pc);
    checkValue("pcSel", pcSel, 1'b1);
    checkValue("branchPc", branchPc, branchTargetOf(pc, offset));
    presentInstr(encodeI(OpBne, 5'd10, 5'd11, offset), pc);
    checkValue("pcSel", pcSel, 1'b0);
    // Unequal operands
    writeReg(5'd11, ~value);
    presentInstr(encodeI(OpBeq, 5'd10, 5'd11, offset), pc);
    checkValue("pcSel", pcSel, 1'b0);
    presentInstr(encodeI(OpBne, 5'd10, 5'd11, offset), pc);
    checkValue("pcSel", pcSel, 1'b1);
    checkValue("branchPc", branchPc, branchTargetOf(pc, offset));
    presentInstr(encodeJ(OpJ, index), pc);
    checkValue("pcSel", pcSel, 1'b1);
    checkValue("branchPc", branchPc, jumpTargetOf(pc, index));
    presentInstr(encodeJ(OpJal, index), pc);
    checkValue("pcSel", pcSel, 1'b1);
    checkValue("branchPc", branchPc, jumpTargetOf(pc, index));
    // Link fields one edge later
    presentInstr(Nop, pc + 32'd4);
    checkValue("exDestAddr", exDestAddr, 5'd31);
    checkValue("exLinkPc", exLinkPc, pc);
    checkValue("exRegWrite", exRegWrite, 1'b1);
    presentInstr(encodeR(5'd12, 5'd0, 5'd0, FnJr), pc);
    checkValue("pcSel", pcSel, 1'b1);
    checkValue("branchPc", branchPc, regMirror[12]);
    finishTest("branches");
  endtask

  task automatic testLoadUse();
    logic [31:0] useAdd;
    useAdd = encodeR(5'd5, 5'd2, 5'd6, FnAdd);
    presentInstr(encodeI(OpLw, 5'd1, 5'd5, 16'h0000), 32'h0000_5000);
    checkValue("stall", stall, 1'b0);
    presentInstr(useAdd, 32'h0000_5004);
    checkValue("stall", stall, 1'b1);
    checkValue("exMemRead", exMemRead, 1'b1);
    // Fetch holds the add while the bubble sits in ID/EX
    presentInstr(useAdd, 32'h0000_5004);
    checkValue("stall", stall, 1'b0);
    checkValue("exRegWrite", exRegWrite, 1'b0);
    checkValue("exMemRead", exMemRead, 1'b0);
    checkValue("exMemWrite", exMemWrite, 1'b0);
    checkValue("exAluOp", exAluOp, AluNop);
    presentInstr(Nop, 32'h0000_5008);
    checkValue("stall", stall, 1'b0);
    checkValue("exAluOp", exAluOp, AluAdd);
    checkValue("exDestAddr", exDestAddr, 5'd6);
    checkValue("exRegWrite", exRegWrite, 1'b1);
    checkValue("exRsData", exRsData, regMirror[5]);
    // Independent add
    presentInstr(encodeI(OpLw, 5'd1, 5'd5, 16'h0000), 32'h0000_6000);
    presentInstr(encodeR(5'd2, 5'd3, 5'd6, FnAdd), 32'h0000_6004);
    checkValue("stall", stall, 1'b0);
    presentInstr(Nop, 32'h0000_6008);
    checkValue("exAluOp", exAluOp, AluAdd);
    // Load into r0
    presentInstr(encodeI(OpLw, 5'd1, 5'd0, 16'h0000), 32'h0000_7000);
    presentInstr(encodeR(5'd0, 5'd0, 5'd6, FnAdd), 32'h0000_7004);
    checkValue("stall", stall, 1'b0);
    presentInstr(Nop, 32'h0000_7008);
    finishTest("loadUse");
  endtask

  //////////////////////////////////////////////////
  // Sequence
  //////////////////////////////////////////////////

  initial begin
    arstN         = 1'b0;
    instr         = Nop;
    pcPlusFour    = 32'd0;
    wbEn          = 1'b0;
    wbAddr        = 5'd0;
    wbData        = 32'd0;
    lcgState      = 32'hcaf6;
    cycleCount    = 0;
    checkCount    = 0;
    errorCount    = 0;
    testErrorBase = 0;
    for (int r = 0; r < 32; r++) begin
      regMirror[r] = 32'd0;
    end
    repeat (4) @(posedge Clock);
    arstN <= 1'b1;
    @(negedge Clock);

    testReset();
    testRegisterFile();
    testImmediates();
    testBranches();
    testLoadUse();

    $display("Checks run: %0d, mismatches: %0d", checkCount, errorCount);
    if (errorCount == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

endmodule

/* decodeStage.sv */
module decodeStage import decodePkg::*; (
  input  logic        Clock,
  input  logic        arstN,
  input  logic [31:0] instr,
  input  logic [31:0] pcPlusFour,
  input  logic        wbEn,
  input  logic [4:0]  wbAddr,
  input  logic [31:0] wbData,
  output logic        pcSel,
  output logic [31:0] branchPc,
  output logic        stall,
  output logic        exRegWrite,
  output logic        exMemRead,
  output logic        exMemWrite,
  output logic        exMemToReg,
  output logic        exAluSrcImm,
  output aluOpT       exAluOp,
  output memWidthT    exMemWidth,
  output logic [4:0]  exDestAddr,
  output logic [31:0] exRsData,
  output logic [31:0] exRtData,
  output logic [31:0] exImm32,
  output logic [31:0] exLinkPc
);

  // Instruction fields
  logic [5:0]  opcode;
  logic [4:0]  rsAddr;
  logic [4:0]  rtAddr;
  logic [4:0]  rdAddr;
  logic [5:0]  funct;

  // Decoded control
  logic        regWrite;
  logic        memRead;
  logic        memWrite;
  logic        memToReg;
  logic        aluSrcImm;
  logic        extendZero;
  aluOpT       aluOp;
  memWidthT    memWidth;
  regDstT      regDst;
  logic        isBranch;
  logic        isBne;
  logic        isJump;
  logic        isJumpReg;
  logic        readsRt;

  // Operands
  logic [31:0] rsData;
  logic [31:0] rtData;
  logic [31:0] imm32;

  assign opcode = instr[31:26];
  assign rsAddr = instr[25:21];
  assign rtAddr = instr[20:16];
  assign rdAddr = instr[15:11];
  assign funct  = instr[5:0];

  //////////////////////////////////////////////////
  // Decode and register read side by side
  //////////////////////////////////////////////////

  instrController instrController_inst (
    .opcode     (opcode),
    .funct      (funct),
    .regWrite   (regWrite),
    .memRead    (memRead),
    .memWrite   (memWrite),
    .memToReg   (memToReg),
    .aluSrcImm  (aluSrcImm),
    .extendZero (extendZero),
    .aluOp      (aluOp),
    .memWidth   (memWidth),
    .regDst     (regDst),
    .isBranch   (isBranch),
    .isBne      (isBne),
    .isJump     (isJump),
    .isJumpReg  (isJumpReg),
    .readsRt    (readsRt)
  );

  registerFile registerFile_inst (
    .Clock  (Clock),
    .arstN  (arstN),
    .rsAddr (rsAddr),
    .rtAddr (rtAddr),
    .wbEn   (wbEn),
    .wbAddr (wbAddr),
    .wbData (wbData),
    .rsData (rsData),
    .rtData (rtData)
  );

  // Redirect decided in this cycle
  branchResolve branchResolve_inst (
    .instr      (instr),
    .pcPlusFour (pcPlusFour),
    .rsData     (rsData),
    .rtData     (rtData),
    .extendZero (extendZero),
    .isBranch   (isBranch),
    .isBne      (isBne),
    .isJump     (isJump),
    .isJumpReg  (isJumpReg),
    .imm32      (imm32),
    .pcSel      (pcSel),
    .branchPc   (branchPc)
  );

  //////////////////////////////////////////////////
  // ID/EX boundary
  //////////////////////////////////////////////////

  idExPipeReg idExPipeReg_inst (
    .Clock       (Clock),
    .arstN       (arstN),
    .rsAddr      (rsAddr),
    .rtAddr      (rtAddr),
    .rdAddr      (rdAddr),
    .readsRt     (readsRt),
    .regWrite    (regWrite),
    .memRead     (memRead),
    .memWrite    (memWrite),
    .memToReg    (memToReg),
    .aluSrcImm   (aluSrcImm),
    .aluOp       (aluOp),
    .memWidth    (memWidth),
    .regDst      (regDst),
    .rsData      (rsData),
    .rtData      (rtData),
    .imm32       (imm32),
    .pcPlusFour  (pcPlusFour),
    .stall       (stall),
    .exRegWrite  (exRegWrite),
    .exMemRead   (exMemRead),
    .exMemWrite  (exMemWrite),
    .exMemToReg  (exMemToReg),
    .exAluSrcImm (exAluSrcImm),
    .exAluOp     (exAluOp),
    .exMemWidth  (exMemWidth),
    .exDestAddr  (exDestAddr),
    .exRsData    (exRsData),
    .exRtData    (exRtData),
    .exImm32     (exImm32),
    .exLinkPc    (exLinkPc)
  );

endmodule

/* idExPipeReg.sv */
module idExPipeReg import decodePkg::*; (
  input  logic        Clock,
  input  logic        arstN,
  input  logic [4:0]  rsAddr,
  input  logic [4:0]  rtAddr,
  input  logic [4:0]  rdAddr,
  input  logic        readsRt,
  input  logic        regWrite,
  input  logic        memRead,
  input  logic        memWrite,
  input  logic        memToReg,
  input  logic        aluSrcImm,
  input  aluOpT       aluOp,
  input  memWidthT    memWidth,
  input  regDstT      regDst,
  input  logic [31:0] rsData,
  input  logic [31:0] rtData,
  input  logic [31:0] imm32,
  input  logic [31:0] pcPlusFour,
  output logic        stall,
  output logic        exRegWrite,
  output logic        exMemRead,
  output logic        exMemWrite,
  output logic        exMemToReg,
  output logic        exAluSrcImm,
  output aluOpT       exAluOp,
  output memWidthT    exMemWidth,
  output logic [4:0]  exDestAddr,
  output logic [31:0] exRsData,
  output logic [31:0] exRtData,
  output logic [31:0] exImm32,
  output logic [31:0] exLinkPc
);

  logic [4:0] destAddr;

  // Final destination number
  always_comb begin
    case (regDst)
      DstRd:   destAddr = rdAddr;
      DstRa:   destAddr = RegRa;
      default: destAddr = rtAddr;
    endcase
  end

  //////////////////////////////////////////////////
  // Load-use hazard
  //////////////////////////////////////////////////

  // Held load whose result the current instruction needs
  // rt only counts when it is actually a source
  assign stall = exMemRead && (exDestAddr != 5'd0) &&
                 ((exDestAddr == rsAddr) || (readsRt && (exDestAddr == rtAddr)));

  //////////////////////////////////////////////////
  // Control fields
  //////////////////////////////////////////////////

  always_ff @(posedge Clock or negedge arstN) begin
    if (!arstN) begin
      exRegWrite  <= 1'b0;
      exMemRead   <= 1'b0;
      exMemWrite  <= 1'b0;
      exMemToReg  <= 1'b0;
      exAluSrcImm <= 1'b0;
      exAluOp     <= AluNop;
      exMemWidth  <= WidthWord;
      exDestAddr  <= 5'd0;
    end else if (stall) begin
      // Bubble while the held instruction waits a cycle
      exRegWrite  <= 1'b0;
      exMemRead   <= 1'b0;
      exMemWrite  <= 1'b0;
      exMemToReg  <= 1'b0;
      exAluSrcImm <= 1'b0;
      exAluOp     <= AluNop;
      exMemWidth  <= WidthWord;
      exDestAddr  <= 5'd0;
    end else begin
      exRegWrite  <= regWrite;
      exMemRead   <= memRead;
      exMemWrite  <= memWrite;
      exMemToReg  <= memToReg;
      exAluSrcImm <= aluSrcImm;
      exAluOp     <= aluOp;
      exMemWidth  <= memWidth;
      exDestAddr  <= destAddr;
    end
  end

  // Operand, immediate and link data
  always_ff @(posedge Clock) begin
    exRsData <= rsData;
    exRtData <= rtData;
    exImm32  <= imm32;
    // Return address for jal
    exLinkPc <= pcPlusFour;
  end

endmodule

/* branchResolve.sv */
module branchResolve (
  input  logic [31:0] instr,
  input  logic [31:0] pcPlusFour,
  input  logic [31:0] rsData,
  input  logic [31:0] rtData,
  input  logic        extendZero,
  input  logic        isBranch,
  input  logic        isBne,
  input  logic        isJump,
  input  logic        isJumpReg,
  output logic [31:0] imm32,
  output logic        pcSel,
  output logic [31:0] branchPc
);

  logic [31:0] branchTarget;
  logic [31:0] jumpTarget;
  logic        operandsEqual;
  logic        branchTaken;

  //////////////////////////////////////////////////
  // Immediate extension
  //////////////////////////////////////////////////

  // andi and ori zero fill, everything else sign fills
  assign imm32 = extendZero ? {16'd0, instr[15:0]} :
                              {{16{instr[15]}}, instr[15:0]};

  //////////////////////////////////////////////////
  // Targets
  //////////////////////////////////////////////////

  // Word offset relative to the next instruction
  assign branchTarget = pcPlusFour + {imm32[29:0], 2'b00};

  // Region bits kept from pc, index fills the rest
  assign jumpTarget = {pcPlusFour[31:28], instr[25:0], 2'b00};

  //////////////////////////////////////////////////
  // Decision
  //////////////////////////////////////////////////

  // Raw register values, no forwarding here
  assign operandsEqual = (rsData == rtData);

  // bne inverts the equality test
  assign branchTaken = isBranch && (isBne ? !operandsEqual : operandsEqual);

  // Any jump redirects
  assign pcSel = branchTaken || isJump || isJumpReg;

  always_comb begin
    if (isJumpReg) begin
      branchPc = rsData;
    end else if (isJump) begin
      branchPc = jumpTarget;
    end else begin
      // Branch target even when not taken
      branchPc = branchTarget;
    end
  end

endmodule

/* registerFile.sv */
module registerFile (
  input  logic        Clock,
  input  logic        arstN,
  input  logic [4:0]  rsAddr,
  input  logic [4:0]  rtAddr,
  input  logic        wbEn,
  input  logic [4:0]  wbAddr,
  input  logic [31:0] wbData,
  output logic [31:0] rsData,
  output logic [31:0] rtData
);

  logic [31:0] regs [32];
  logic        wbValid;

  // Writes to r0 are dropped
  assign wbValid = wbEn && (wbAddr != 5'd0);

  //////////////////////////////////////////////////
  // Write port
  //////////////////////////////////////////////////

  always_ff @(posedge Clock or negedge arstN) begin
    if (!arstN) begin
      for (int i = 0; i < 32; i++) begin
        regs[i] <= 32'd0;
      end
    end else if (wbValid) begin
      regs[wbAddr] <= wbData;
    end
  end

  //////////////////////////////////////////////////
  // Read ports with writeback bypass
  //////////////////////////////////////////////////

  always_comb begin
    // r0 first, then same-cycle write, then stored value
    if (rsAddr == 5'd0) begin
      rsData = 32'd0;
    end else if (wbValid && (wbAddr == rsAddr)) begin
      rsData = wbData;
    end else begin
      rsData = regs[rsAddr];
    end

    if (rtAddr == 5'd0) begin
      rtData = 32'd0;
    end else if (wbValid && (wbAddr == rtAddr)) begin
      rtData = wbData;
    end else begin
      rtData = regs[rtAddr];
    end
  end

endmodule

/* instrController.sv */
module instrController import decodePkg::*; (
  input  logic [5:0] opcode,
  input  logic [5:0] funct,
  output logic       regWrite,
  output logic       memRead,
  output logic       memWrite,
  output logic       memToReg,
  output logic       aluSrcImm,
  output logic       extendZero,
  output aluOpT      aluOp,
  output memWidthT   memWidth,
  output regDstT     regDst,
  output logic       isBranch,
  output logic       isBne,
  output logic       isJump,
  output logic       isJumpReg,
  output logic       readsRt
);

  always_comb begin
    // Bubble pattern unless an opcode below claims the instruction
    regWrite   = 1'b0;
    memRead    = 1'b0;
    memWrite   = 1'b0;
    memToReg   = 1'b0;
    aluSrcImm  = 1'b0;
    extendZero = 1'b0;
    aluOp      = AluNop;
    memWidth   = WidthWord;
    regDst     = DstRt;
    isBranch   = 1'b0;
    isBne      = 1'b0;
    isJump     = 1'b0;
    isJumpReg  = 1'b0;
    readsRt    = 1'b0;

    case (opcode)
      OpRType: begin
        // Register-register ops write rd and read both sources
        case (funct)
          FnAdd, FnSub, FnAnd, FnOr, FnSlt: begin
            regWrite = 1'b1;
            regDst   = DstRd;
            readsRt  = 1'b1;
            case (funct)
              FnSub:   aluOp = AluSub;
              FnAnd:   aluOp = AluAnd;
              FnOr:    aluOp = AluOr;
              FnSlt:   aluOp = AluSlt;
              default: aluOp = AluAdd;
            endcase
          end
          // Target comes straight from rs
          FnJr:    isJumpReg = 1'b1;
          default: ;
        endcase
      end

      // Immediate arithmetic and logic
      OpAddi, OpAndi, OpOri, OpLui: begin
        regWrite  = 1'b1;
        aluSrcImm = 1'b1;
        case (opcode)
          OpAndi: begin
            aluOp      = AluAnd;
            extendZero = 1'b1;
          end
          OpOri: begin
            aluOp      = AluOr;
            extendZero = 1'b1;
          end
          OpLui:   aluOp = AluLui;
          default: aluOp = AluAdd;
        endcase
      end

      // Loads address memory at rs plus offset
      OpLw, OpLh, OpLb: begin
        regWrite  = 1'b1;
        memRead   = 1'b1;
        memToReg  = 1'b1;
        aluSrcImm = 1'b1;
        aluOp     = AluAdd;
        memWidth  = (opcode == OpLw) ? WidthWord :
                    (opcode == OpLh) ? WidthHalf : WidthByte;
      end

      // Stores carry rt as write data
      OpSw, OpSh, OpSb: begin
        memWrite  = 1'b1;
        aluSrcImm = 1'b1;
        aluOp     = AluAdd;
        readsRt   = 1'b1;
        memWidth  = (opcode == OpSw) ? WidthWord :
                    (opcode == OpSh) ? WidthHalf : WidthByte;
      end

      // Compared in decode, nothing left for execute
      OpBeq, OpBne: begin
        isBranch = 1'b1;
        isBne    = (opcode == OpBne);
        readsRt  = 1'b1;
      end

      OpJ: isJump = 1'b1;

      // Link value rides along as exLinkPc
      OpJal: begin
        isJump   = 1'b1;
        regWrite = 1'b1;
        regDst   = DstRa;
      end

      default: ;
    endcase
  end

endmodule

/* decodePkg.sv */
package decodePkg;

  //////////////////////////////////////////////////
  // Primary opcodes, instr[31:26]
  //////////////////////////////////////////////////

  localparam logic [5:0] OpRType = 6'b000000;
  localparam logic [5:0] OpJ     = 6'b000010;
  localparam logic [5:0] OpJal   = 6'b000011;
  localparam logic [5:0] OpBeq   = 6'b000100;
  localparam logic [5:0] OpBne   = 6'b000101;
  localparam logic [5:0] OpAddi  = 6'b001000;
  localparam logic [5:0] OpAndi  = 6'b001100;
  localparam logic [5:0] OpOri   = 6'b001101;
  localparam logic [5:0] OpLui   = 6'b001111;
  // Loads
  localparam logic [5:0] OpLb    = 6'b100000;
  localparam logic [5:0] OpLh    = 6'b100001;
  localparam logic [5:0] OpLw    = 6'b100011;
  // Stores
  localparam logic [5:0] OpSb    = 6'b101000;
  localparam logic [5:0] OpSh    = 6'b101001;
  localparam logic [5:0] OpSw    = 6'b101011;

  //////////////////////////////////////////////////
  // R-type function codes, instr[5:0]
  //////////////////////////////////////////////////

  localparam logic [5:0] FnJr  = 6'b001000;
  localparam logic [5:0] FnAdd = 6'b100000;
  localparam logic [5:0] FnSub = 6'b100010;
  localparam logic [5:0] FnAnd = 6'b100100;
  localparam logic [5:0] FnOr  = 6'b100101;
  localparam logic [5:0] FnSlt = 6'b101010;

  // Link register written by jal
  localparam logic [4:0] RegRa = 5'd31;

  // Operation requested from execute
  typedef enum logic [3:0] {
    AluAdd,
    AluSub,
    AluAnd,
    AluOr,
    AluSlt,
    AluLui,
    AluNop
  } aluOpT;

  // Load and store access size
  typedef enum logic [1:0] {
    WidthWord,
    WidthHalf,
    WidthByte
  } memWidthT;

  // Source of the destination register number
  typedef enum logic [1:0] {
    DstRt,
    DstRd,
    DstRa
  } regDstT;

endpackage
